//--- all.f
source/mmio_map_pkg.sv
source/axil_pkg.sv
source/axil_slave_port.sv
source/mmio_decode.sv
source/ram_bank.sv
source/periph_regs.sv
source/read_collect.sv
source/mmio_subsystem.sv
dv/mmio_checker.sv
dv/tb_mmio.sv

//--- Bender.yml
package:
  name: mmio_subsystem

sources:
  - source/mmio_map_pkg.sv
  - source/axil_pkg.sv
  - source/axil_slave_port.sv
  - source/mmio_decode.sv
  - source/ram_bank.sv
  - source/periph_regs.sv
  - source/read_collect.sv
  - source/mmio_subsystem.sv
  - target: simulation
    files:
      - dv/mmio_checker.sv
      - dv/tb_mmio.sv

//--- dv/tb_mmio.sv
`timescale 1ns/10ps

module tb_mmio
    import mmio_map_pkg::*;
    import axil_pkg::*;
#(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 64,
    parameter int NUM_TXNS   = 300
);

    localparam int RAM_WORDS  = NUM_BANKS * BANK_WORDS;
    // Fill pass plus random pass, at most 16 cycles per transaction
    localparam int MAX_CYCLES = (RAM_WORDS + NUM_TXNS) * 16 + 100;
    // Longest wait for B or R once ready is up
    localparam int RESP_WAIT  = 4;

    logic                  clk;
    logic                  rst;
    logic                  awvalid;
    logic                  awready;
    logic [ADDR_WIDTH-1:0] awaddr;
    logic                  wvalid;
    logic                  wready;
    logic [DATA_WIDTH-1:0] wdata;
    logic [STRB_WIDTH-1:0] wstrb;
    logic                  bvalid;
    logic                  bready;
    logic [1:0]            bresp;
    logic                  arvalid;
    logic                  arready;
    logic [ADDR_WIDTH-1:0] araddr;
    logic                  rvalid;
    logic                  rready;
    logic [DATA_WIDTH-1:0] rdata;
    logic [1:0]            rresp;
    logic [KB_WIDTH-1:0]   kb_data;
    logic                  kb_ready;
    logic                  kb_pop;
    logic [SWT_WIDTH-1:0]  switches;
    logic [RTC_WIDTH-1:0]  rtc_value;
    logic [SEG_WIDTH-1:0]  seg_out;
    logic [LED_WIDTH-1:0]  led_out;

    // Reference model state and expected responses
    logic [DATA_WIDTH-1:0] ram_model [RAM_WORDS];
    logic [SEG_WIDTH-1:0]  exp_seg;
    logic [LED_WIDTH-1:0]  exp_led;
    logic [1:0]            exp_bresp;
    logic [1:0]            exp_rresp;
    logic [DATA_WIDTH-1:0] exp_rdata;
    int                    exp_pops;

    int seed;
    int cycles      = 0;
    int run_errors  = 0;
    int writes_sent = 0;
    int reads_sent  = 0;

    mmio_subsystem #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) dut_i (.*);

    mmio_checker chk_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old,
                                                          input logic [DATA_WIDTH-1:0] data,
                                                          input logic [STRB_WIDTH-1:0] strb);
        logic [DATA_WIDTH-1:0] res;
        res = old;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // RAM gets most of the traffic
    function automatic region_e pick_region();
        int r;
        r = $unsigned($random(seed)) % 10;
        if (r < 4) begin
            return RAM;
        end
        return region_e'(r - 3);
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] pick_addr(input region_e region);
        logic [ADDR_WIDTH-1:0] offs;
        offs = 32'(($unsigned($random(seed)) % RAM_WORDS) * 8);
        case (region)
            RAM: return RAM_BASE + offs;
            KBD: return KBD_ADDR;
            SWT: return SWT_ADDR;
            SEG: return SEG_ADDR;
            LED: return LED_ADDR;
            RTC: return RTC_ADDR;
            default: begin
                // Past the RAM end, a gap between windows, or low memory
                case (offs[4:3])
                    2'd0:    return RAM_BASE + RAM_WORDS * 8 + offs;
                    2'd1:    return 32'hA000_0050;
                    default: return offs;
                endcase
            end
        endcase
    endfunction

    task automatic apply_write(input region_e region, input logic [ADDR_WIDTH-1:0] addr,
                               input logic [DATA_WIDTH-1:0] data,
                               input logic [STRB_WIDTH-1:0] strb);
        logic [DATA_WIDTH-1:0] merged;
        int                    word;
        word      = (addr - RAM_BASE) >> 3;
        exp_bresp = RESP_OKAY;
        case (region)
            RAM: begin
                ram_model[word] = merge_bytes(ram_model[word], data, strb);
            end
            SEG: begin
                merged  = merge_bytes(DATA_WIDTH'(exp_seg), data, strb);
                exp_seg = merged[SEG_WIDTH-1:0];
            end
            LED: begin
                merged  = merge_bytes(DATA_WIDTH'(exp_led), data, strb);
                exp_led = merged[LED_WIDTH-1:0];
            end
            default: exp_bresp = RESP_SLVERR;
        endcase
    endtask

    task automatic apply_read(input region_e region, input logic [ADDR_WIDTH-1:0] addr);
        exp_rresp = RESP_OKAY;
        case (region)
            RAM: exp_rdata = ram_model[(addr - RAM_BASE) >> 3];
            KBD: begin
                exp_rdata = '0;
                if (kb_ready) begin
                    exp_rdata[KB_WIDTH-1:0] = kb_data;
                    exp_pops++;
                end
            end
            SWT: exp_rdata = DATA_WIDTH'(switches);
            SEG: exp_rdata = DATA_WIDTH'(exp_seg);
            LED: exp_rdata = DATA_WIDTH'(exp_led);
            RTC: exp_rdata = DATA_WIDTH'(rtc_value);
            default: begin
                exp_rdata = '0;
                exp_rresp = RESP_SLVERR;
            end
        endcase
    endtask

    task automatic write_txn(input region_e region, input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] data,
                             input logic [STRB_WIDTH-1:0] strb);
        int hold;
        int waited;
        hold = $unsigned($random(seed)) % 5;
        @(negedge clk);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        @(posedge clk);
        while (!awready) begin
            @(posedge clk);
        end
        // Valid stays up while B is pending to probe the back-pressure
        @(negedge clk);
        apply_write(region, addr, data, strb);
        writes_sent++;
        repeat (hold) @(negedge clk);
        bready = 1'b1;
        waited = 0;
        @(posedge clk);
        while (!bvalid && waited < RESP_WAIT) begin
            @(posedge clk);
            waited++;
        end
        @(negedge clk);
        bready  = 1'b0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic read_txn(input region_e region, input logic [ADDR_WIDTH-1:0] addr);
        int hold;
        int waited;
        hold = $unsigned($random(seed)) % 5;
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        @(posedge clk);
        while (!arready) begin
            @(posedge clk);
        end
        @(negedge clk);
        apply_read(region, addr);
        reads_sent++;
        repeat (hold) @(negedge clk);
        rready = 1'b1;
        waited = 0;
        @(posedge clk);
        while (!rvalid && waited < RESP_WAIT) begin
            @(posedge clk);
            waited++;
        end
        @(negedge clk);
        rready  = 1'b0;
        arvalid = 1'b0;
    endtask

    task automatic report_counts();
        $display("Errors: %0d mismatches, %0d other failures",
                 chk_i.mismatches, chk_i.failures + run_errors);
    endtask

    always @(negedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            run_errors++;
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            report_counts();
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        region_e               region;
        logic [ADDR_WIDTH-1:0] addr;
        logic [31:0]           rnd;
        seed      = 32'h42c5bc02;
        rst       = 1'b1;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        bready    = 1'b0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        kb_data   = '0;
        kb_ready  = 1'b0;
        switches  = '0;
        rtc_value = '0;
        exp_seg   = '0;
        exp_led   = '0;
        exp_bresp = RESP_OKAY;
        exp_rresp = RESP_OKAY;
        exp_rdata = '0;
        exp_pops  = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Known contents in every RAM word first
        for (int i = 0; i < RAM_WORDS; i++) begin
            addr = RAM_BASE + 32'(i * 8);
            write_txn(RAM, addr, {~addr, addr}, '1);
        end

        repeat (NUM_TXNS) begin
            rnd       = $random(seed);
            kb_ready  = rnd[0];
            kb_data   = rnd[15:8];
            switches  = rnd[23:16];
            rtc_value = {$random(seed), $random(seed)};
            region    = pick_region();
            addr      = pick_addr(region);
            rnd       = $random(seed);
            if (rnd[0]) begin
                write_txn(region, addr, {$random(seed), $random(seed)}, rnd[15:8]);
            end else begin
                read_txn(region, addr);
            end
        end

        repeat (4) @(negedge clk);
        if (chk_i.b_count != writes_sent || chk_i.r_count != reads_sent) begin
            run_errors++;
            $display("Missing response: %0d writes and %0d reads sent, %0d B and %0d R seen",
                     writes_sent, reads_sent, chk_i.b_count, chk_i.r_count);
        end
        if (chk_i.pop_count != exp_pops) begin
            run_errors++;
            $display("kb_pop pulsed %0d times in total, expected %0d", chk_i.pop_count, exp_pops);
        end
        report_counts();
        if (chk_i.mismatches + chk_i.failures + run_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- dv/mmio_checker.sv
`timescale 1ns/10ps

module mmio_checker
    import mmio_map_pkg::*;
    import axil_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  awvalid,
    input logic                  awready,
    input logic                  wvalid,
    input logic                  wready,
    input logic                  bvalid,
    input logic                  bready,
    input logic [1:0]            bresp,
    input logic                  arvalid,
    input logic                  arready,
    input logic                  rvalid,
    input logic                  rready,
    input logic [DATA_WIDTH-1:0] rdata,
    input logic [1:0]            rresp,
    input logic                  kb_pop,
    input logic [SEG_WIDTH-1:0]  seg_out,
    input logic [LED_WIDTH-1:0]  led_out
);

    int mismatches = 0;
    int failures   = 0;
    int aw_count   = 0;
    int b_count    = 0;
    int ar_count   = 0;
    int r_count    = 0;
    int pop_count  = 0;

    // Response that was waiting at the previous edge
    logic                  b_held = 1'b0;
    logic                  r_held = 1'b0;
    logic [1:0]            held_bresp;
    logic [1:0]            held_rresp;
    logic [DATA_WIDTH-1:0] held_rdata;

    task automatic compare_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                                 input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s: expected 0x%0h, actual 0x%0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic note_failure(input string what);
        failures++;
        $display("%s at %0t", what, $time);
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (kb_pop) begin
                pop_count++;
            end
            // AW and W are accepted in the same cycle
            if ((awvalid && awready) != (wvalid && wready)) begin
                note_failure("AW and W handshakes did not happen in the same cycle");
            end
            if (awvalid && awready) begin
                if (aw_count != b_count) begin
                    note_failure("Write accepted while a B response was still pending");
                end
                aw_count++;
            end
            if (arvalid && arready) begin
                if (ar_count != r_count) begin
                    note_failure("Read accepted while the previous read was unfinished");
                end
                ar_count++;
            end
            if (b_held) begin
                if (!bvalid) begin
                    note_failure("bvalid dropped before bready was seen");
                end
                compare_value("bresp (held)", held_bresp, bresp);
            end
            if (r_held) begin
                if (!rvalid) begin
                    note_failure("rvalid dropped before rready was seen");
                end
                compare_value("rdata (held)", held_rdata, rdata);
                compare_value("rresp (held)", held_rresp, rresp);
            end
            // Output registers settle one cycle after the write handshake
            if (bvalid) begin
                compare_value("seg_out", tb_mmio.exp_seg, seg_out);
                compare_value("led_out", tb_mmio.exp_led, led_out);
                if (bready) begin
                    compare_value("bresp", tb_mmio.exp_bresp, bresp);
                    b_count++;
                end
            end
            if (rvalid && rready) begin
                compare_value("rdata", tb_mmio.exp_rdata, rdata);
                compare_value("rresp", tb_mmio.exp_rresp, rresp);
                if (pop_count != tb_mmio.exp_pops) begin
                    note_failure($sformatf("kb_pop pulsed %0d times, expected %0d",
                                           pop_count, tb_mmio.exp_pops));
                    pop_count = tb_mmio.exp_pops;
                end
                r_count++;
            end
            b_held     = bvalid && !bready;
            r_held     = rvalid && !rready;
            held_bresp = bresp;
            held_rresp = rresp;
            held_rdata = rdata;
        end
    end

endmodule

//--- source/mmio_subsystem.sv
`timescale 1ns/10ps

module mmio_subsystem
    import mmio_map_pkg::*;
    import axil_pkg::*;
#(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [ADDR_WIDTH-1:0] awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic [STRB_WIDTH-1:0] wstrb,
    output logic                  bvalid,
    input  logic                  bready,
    output logic [1:0]            bresp,
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [ADDR_WIDTH-1:0] araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic [1:0]            rresp,
    input  logic [KB_WIDTH-1:0]   kb_data,
    input  logic                  kb_ready,
    output logic                  kb_pop,
    input  logic [SWT_WIDTH-1:0]  switches,
    input  logic [RTC_WIDTH-1:0]  rtc_value,
    output logic [SEG_WIDTH-1:0]  seg_out,
    output logic [LED_WIDTH-1:0]  led_out
);

    localparam int BANK_BITS = $clog2(NUM_BANKS);
    localparam int WORD_BITS = $clog2(BANK_WORDS);

    logic                            req_valid;
    logic                            req_write;
    logic [ADDR_WIDTH-1:0]           req_addr;
    logic [DATA_WIDTH-1:0]           req_wdata;
    logic [STRB_WIDTH-1:0]           req_wstrb;
    logic                            wr_err;
    logic                            rsp_valid;
    logic [DATA_WIDTH-1:0]           rsp_data;
    logic                            rsp_err;
    logic [NUM_BANKS-1:0]            bank_wen;
    logic [NUM_BANKS-1:0]            bank_ren;
    logic [WORD_BITS-1:0]            bank_addr;
    logic [DATA_WIDTH-1:0]           bank_wdata;
    logic [STRB_WIDTH-1:0]           bank_wstrb;
    logic [NUM_BANKS*DATA_WIDTH-1:0] bank_rdata;
    logic                            seg_we;
    logic                            led_we;
    logic                            periph_ren;
    region_e                         periph_sel;
    logic [DATA_WIDTH-1:0]           periph_rdata;
    region_e                         rd_sel_region;
    logic [BANK_BITS-1:0]            rd_sel_bank;
    logic                            rd_err;
    logic                            rd_pending;

    axil_slave_port u_port (
        .clk       (clk),
        .rst       (rst),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_wstrb (req_wstrb),
        .wr_err    (wr_err),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_err   (rsp_err)
    );

    mmio_decode #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) u_decode (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_wstrb     (req_wstrb),
        .wr_err        (wr_err),
        .bank_wen      (bank_wen),
        .bank_ren      (bank_ren),
        .bank_addr     (bank_addr),
        .bank_wdata    (bank_wdata),
        .bank_wstrb    (bank_wstrb),
        .seg_we        (seg_we),
        .led_we        (led_we),
        .periph_ren    (periph_ren),
        .periph_sel    (periph_sel),
        .rd_sel_region (rd_sel_region),
        .rd_sel_bank   (rd_sel_bank),
        .rd_err        (rd_err),
        .rd_pending    (rd_pending)
    );

    // Word-interleaved banks
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        ram_bank #(
            .BANK_WORDS (BANK_WORDS)
        ) u_bank (
            .clk   (clk),
            .wen   (bank_wen[i]),
            .ren   (bank_ren[i]),
            .addr  (bank_addr),
            .wdata (bank_wdata),
            .wstrb (bank_wstrb),
            .rdata (bank_rdata[i*DATA_WIDTH +: DATA_WIDTH])
        );
    end

    periph_regs u_periph (
        .clk          (clk),
        .rst          (rst),
        .seg_we       (seg_we),
        .led_we       (led_we),
        .wdata        (bank_wdata),
        .wstrb        (bank_wstrb),
        .periph_ren   (periph_ren),
        .periph_sel   (periph_sel),
        .kb_data      (kb_data),
        .kb_ready     (kb_ready),
        .switches     (switches),
        .rtc_value    (rtc_value),
        .seg_out      (seg_out),
        .led_out      (led_out),
        .kb_pop       (kb_pop),
        .periph_rdata (periph_rdata)
    );

    read_collect #(
        .NUM_BANKS (NUM_BANKS)
    ) u_collect (
        .rd_pending    (rd_pending),
        .rd_sel_region (rd_sel_region),
        .rd_sel_bank   (rd_sel_bank),
        .rd_err        (rd_err),
        .bank_rdata    (bank_rdata),
        .periph_rdata  (periph_rdata),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .rsp_err       (rsp_err)
    );

endmodule

//--- source/read_collect.sv
`timescale 1ns/10ps

module read_collect
    import mmio_map_pkg::*;
    import axil_pkg::*;
#(
    parameter int NUM_BANKS = 4
) (
    input  logic                            rd_pending,
    input  region_e                         rd_sel_region,
    input  logic [$clog2(NUM_BANKS)-1:0]    rd_sel_bank,
    input  logic                            rd_err,
    input  logic [NUM_BANKS*DATA_WIDTH-1:0] bank_rdata,
    input  logic [DATA_WIDTH-1:0]           periph_rdata,
    output logic                            rsp_valid,
    output logic [DATA_WIDTH-1:0]           rsp_data,
    output logic                            rsp_err
);

    assign rsp_valid = rd_pending;
    assign rsp_err   = rd_err;

    // Errors read as zero
    always_comb begin
        if (rd_err) begin
            rsp_data = '0;
        end else if (rd_sel_region == RAM) begin
            rsp_data = bank_rdata[rd_sel_bank*DATA_WIDTH +: DATA_WIDTH];
        end else begin
            rsp_data = periph_rdata;
        end
    end

endmodule

//--- source/periph_regs.sv
`timescale 1ns/10ps

module periph_regs
    import mmio_map_pkg::*;
    import axil_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  seg_we,
    input  logic                  led_we,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic [STRB_WIDTH-1:0] wstrb,
    input  logic                  periph_ren,
    input  region_e               periph_sel,
    input  logic [KB_WIDTH-1:0]   kb_data,
    input  logic                  kb_ready,
    input  logic [SWT_WIDTH-1:0]  switches,
    input  logic [RTC_WIDTH-1:0]  rtc_value,
    output logic [SEG_WIDTH-1:0]  seg_out,
    output logic [LED_WIDTH-1:0]  led_out,
    output logic                  kb_pop,
    output logic [DATA_WIDTH-1:0] periph_rdata
);

    // Output registers take the strobed low bytes
    always_ff @(posedge clk) begin
        if (rst) begin
            seg_out <= '0;
            led_out <= '0;
        end else begin
            for (int b = 0; b < SEG_WIDTH / 8; b++) begin
                if (seg_we && wstrb[b]) begin
                    seg_out[8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            for (int b = 0; b < LED_WIDTH / 8; b++) begin
                if (led_we && wstrb[b]) begin
                    led_out[8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Pop only when a byte was actually handed out
    always_ff @(posedge clk) begin
        if (rst) begin
            kb_pop <= 1'b0;
        end else begin
            kb_pop <= periph_ren && periph_sel == KBD && kb_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (periph_ren) begin
            case (periph_sel)
                KBD:     periph_rdata <= kb_ready ? DATA_WIDTH'(kb_data) : '0;
                SWT:     periph_rdata <= DATA_WIDTH'(switches);
                SEG:     periph_rdata <= DATA_WIDTH'(seg_out);
                LED:     periph_rdata <= DATA_WIDTH'(led_out);
                RTC:     periph_rdata <= DATA_WIDTH'(rtc_value);
                default: periph_rdata <= '0;
            endcase
        end
    end

endmodule

//--- source/ram_bank.sv
`timescale 1ns/10ps

module ram_bank
    import axil_pkg::*;
#(
    parameter int BANK_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          wen,
    input  logic                          ren,
    input  logic [$clog2(BANK_WORDS)-1:0] addr,
    input  logic [DATA_WIDTH-1:0]         wdata,
    input  logic [STRB_WIDTH-1:0]         wstrb,
    output logic [DATA_WIDTH-1:0]         rdata
);

    axil_word_u mem [BANK_WORDS];
    axil_word_u wword;

    assign wword.dword = wdata;

    // Only strobed bytes are touched
    always_ff @(posedge clk) begin
        if (wen) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (wstrb[b]) begin
                    mem[addr].bytes[b] <= wword.bytes[b];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ren) begin
            rdata <= mem[addr].dword;
        end
    end

    a_single_port: assert property (@(posedge clk) !(wen && ren));

endmodule

//--- source/mmio_decode.sv
`timescale 1ns/10ps

module mmio_decode
    import mmio_map_pkg::*;
    import axil_pkg::*;
#(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  logic                          req_write,
    input  logic [ADDR_WIDTH-1:0]         req_addr,
    input  logic [DATA_WIDTH-1:0]         req_wdata,
    input  logic [STRB_WIDTH-1:0]         req_wstrb,
    output logic                          wr_err,
    output logic [NUM_BANKS-1:0]          bank_wen,
    output logic [NUM_BANKS-1:0]          bank_ren,
    output logic [$clog2(BANK_WORDS)-1:0] bank_addr,
    output logic [DATA_WIDTH-1:0]         bank_wdata,
    output logic [STRB_WIDTH-1:0]         bank_wstrb,
    output logic                          seg_we,
    output logic                          led_we,
    output logic                          periph_ren,
    output region_e                       periph_sel,
    output region_e                       rd_sel_region,
    output logic [$clog2(NUM_BANKS)-1:0]  rd_sel_bank,
    output logic                          rd_err,
    output logic                          rd_pending
);

    localparam int BANK_BITS = $clog2(NUM_BANKS);
    localparam int WORD_BITS = $clog2(BANK_WORDS);
    localparam logic [ADDR_WIDTH-1:0] RAM_LEN = NUM_BANKS * BANK_WORDS * 8;

    logic [ADDR_WIDTH-1:0] ram_off;
    logic [BANK_BITS-1:0]  bank_idx;
    logic                  addr_err;
    region_e               region;

    function automatic logic in_window(input logic [ADDR_WIDTH-1:0] addr,
                                       input logic [ADDR_WIDTH-1:0] base);
        return (addr >= base) && (addr < base + PERI_LEN);
    endfunction

    // Low word-address bits pick the bank, the rest the word inside it
    assign ram_off  = req_addr - RAM_BASE;
    assign bank_idx = ram_off[3 +: BANK_BITS];

    always_comb begin
        if (req_addr >= RAM_BASE && ram_off < RAM_LEN) begin
            region = RAM;
        end else if (in_window(req_addr, KBD_ADDR)) begin
            region = KBD;
        end else if (in_window(req_addr, SWT_ADDR)) begin
            region = SWT;
        end else if (in_window(req_addr, SEG_ADDR)) begin
            region = SEG;
        end else if (in_window(req_addr, LED_ADDR)) begin
            region = LED;
        end else if (in_window(req_addr, RTC_ADDR)) begin
            region = RTC;
        end else begin
            region = NONE;
        end
    end

    // Unmapped, or a write into a read-only register
    assign addr_err = (region == NONE) || (req_write && region inside {KBD, SWT, RTC});
    assign wr_err   = req_valid && req_write && addr_err;

    always_comb begin
        bank_wen = '0;
        bank_ren = '0;
        if (req_valid && region == RAM) begin
            if (req_write) begin
                bank_wen[bank_idx] = 1'b1;
            end else begin
                bank_ren[bank_idx] = 1'b1;
            end
        end
    end

    assign bank_addr  = ram_off[3 + BANK_BITS +: WORD_BITS];
    assign bank_wdata = req_wdata;
    assign bank_wstrb = req_wstrb;

    assign seg_we     = req_valid && req_write && region == SEG;
    assign led_we     = req_valid && req_write && region == LED;
    assign periph_ren = req_valid && !req_write && !addr_err && region != RAM;
    assign periph_sel = region;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= req_valid && !req_write;
        end
    end

    // Selects for the collector in the cycle after the request
    always_ff @(posedge clk) begin
        if (req_valid && !req_write) begin
            rd_sel_region <= region;
            rd_sel_bank   <= bank_idx;
            rd_err        <= addr_err;
        end
    end

    a_wen_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(bank_wen));
    a_ren_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(bank_ren));
    a_no_rw_mix: assert property (
        @(posedge clk) disable iff (rst) !(|bank_wen && |bank_ren)
    );

endmodule

//--- source/axil_slave_port.sv
`timescale 1ns/10ps

module axil_slave_port
    import mmio_map_pkg::*;
    import axil_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [ADDR_WIDTH-1:0] awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic [STRB_WIDTH-1:0] wstrb,
    output logic                  bvalid,
    input  logic                  bready,
    output logic [1:0]            bresp,
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [ADDR_WIDTH-1:0] araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  req_valid,
    output logic                  req_write,
    output logic [ADDR_WIDTH-1:0] req_addr,
    output logic [DATA_WIDTH-1:0] req_wdata,
    output logic [STRB_WIDTH-1:0] req_wstrb,
    input  logic                  wr_err,
    input  logic                  rsp_valid,
    input  logic [DATA_WIDTH-1:0] rsp_data,
    input  logic                  rsp_err
);

    logic wr_go;
    logic rd_go;
    logic rd_inflight;

    // Write needs both channels and a free B slot; it beats a read
    assign wr_go = awvalid && wvalid && !bvalid;
    assign rd_go = arvalid && !rd_inflight && !rvalid && !wr_go;

    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;

    assign req_valid = wr_go || rd_go;
    assign req_write = wr_go;
    assign req_addr  = wr_go ? awaddr : araddr;
    assign req_wdata = wdata;
    assign req_wstrb = wr_go ? wstrb : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wr_go) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // Read stays busy from AR accept until the collector answers
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_inflight <= 1'b0;
            rvalid      <= 1'b0;
        end else begin
            if (rd_go) begin
                rd_inflight <= 1'b1;
            end else if (rsp_valid) begin
                rd_inflight <= 1'b0;
            end
            if (rsp_valid) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            rdata <= rsp_data;
            rresp <= rsp_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    a_r_hold: assert property (
        @(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    );

endmodule

//--- source/axil_pkg.sv
package axil_pkg;

    localparam int DATA_WIDTH = 64;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Same data word seen whole or byte by byte
    typedef union packed {
        logic [DATA_WIDTH-1:0]      dword;
        logic [STRB_WIDTH-1:0][7:0] bytes;
    } axil_word_u;

endpackage

//--- source/mmio_map_pkg.sv
package mmio_map_pkg;

    localparam int ADDR_WIDTH = 32;

    // Region base addresses
    localparam logic [ADDR_WIDTH-1:0] RAM_BASE = 32'h8000_0000;
    localparam logic [ADDR_WIDTH-1:0] KBD_ADDR = 32'hA000_0060;
    localparam logic [ADDR_WIDTH-1:0] SWT_ADDR = 32'hA000_0070;
    localparam logic [ADDR_WIDTH-1:0] SEG_ADDR = 32'hA000_0080;
    localparam logic [ADDR_WIDTH-1:0] LED_ADDR = 32'hA000_0090;
    localparam logic [ADDR_WIDTH-1:0] RTC_ADDR = 32'hA000_0048;

    // Every peripheral owns one 8-byte window
    localparam logic [ADDR_WIDTH-1:0] PERI_LEN = 32'd8;

    localparam int KB_WIDTH  = 8;
    localparam int SWT_WIDTH = 8;
    localparam int SEG_WIDTH = 32;
    localparam int LED_WIDTH = 16;
    localparam int RTC_WIDTH = 64;

    typedef enum logic [2:0] {
        RAM  = 3'd0,
        KBD  = 3'd1,
        SWT  = 3'd2,
        SEG  = 3'd3,
        LED  = 3'd4,
        RTC  = 3'd5,
        NONE = 3'd6
    } region_e;

endpackage
